/* hdl/axil_pkg.sv */
// Shared AXI-lite widths, response codes and instruction memory defaults, imported by all RTL
package axil_pkg;

  // Bus widths
  localparam int AXIL_DATA_W = 64;
  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_PROT_W = 3;
  localparam int AXIL_RESP_W = 2;

  // RISC-V base ISA instruction width
  localparam int INST_W = 32;

  // Response codes, only the two the SRAM ever returns
  localparam logic [AXIL_RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [AXIL_RESP_W-1:0] RESP_SLVERR = 2'b10;

  // Protection attributes
  // Data access, unprivileged, secure
  localparam logic [AXIL_PROT_W-1:0] PROT_DATA = 3'b000;
  // Instruction access, unprivileged, secure
  localparam logic [AXIL_PROT_W-1:0] PROT_INST = 3'b100;

  // Default instruction memory window
  localparam logic [31:0] IMEM_BASE_DEF = 32'h8000_0000;
  // Depth in data-width words
  localparam int IMEM_DEPTH_DEF = 256;

endpackage

/* hdl/axil_if.sv */
// AXI-lite bus bundle joining the instruction SRAM slave to the fetch and loader masters
interface axil_if #(
  parameter int DATA_WIDTH = axil_pkg::AXIL_DATA_W,
  parameter int ADDR_WIDTH = axil_pkg::AXIL_ADDR_W
);
  import axil_pkg::*;

  localparam int STRB_W = DATA_WIDTH / 8;

  // Write address channel
  logic                   awvalid;
  logic                   awready;
  logic [ADDR_WIDTH-1:0]  awaddr;
  logic [AXIL_PROT_W-1:0] awprot;

  // Write data channel
  logic                  wvalid;
  logic                  wready;
  logic [DATA_WIDTH-1:0] wdata;
  logic [STRB_W-1:0]     wstrb;

  // Write response channel
  logic                   bvalid;
  logic                   bready;
  logic [AXIL_RESP_W-1:0] bresp;

  // Read address channel
  logic                   arvalid;
  logic                   arready;
  logic [ADDR_WIDTH-1:0]  araddr;
  logic [AXIL_PROT_W-1:0] arprot;

  // Read data channel
  logic                   rvalid;
  logic                   rready;
  logic [DATA_WIDTH-1:0]  rdata;
  logic [AXIL_RESP_W-1:0] rresp;

  modport master (
    output awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
    output arvalid, araddr, arprot, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  modport slave (
    input  awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
    input  arvalid, araddr, arprot, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

endinterface

/* hdl/axil_inst_sram.sv */
// AXI-lite instruction SRAM slave with strobed writes, registered reads and a range-checked window
module axil_inst_sram #(
  parameter int                  DATA_WIDTH = axil_pkg::AXIL_DATA_W,
  parameter int                  ADDR_WIDTH = axil_pkg::AXIL_ADDR_W,
  parameter int                  MEM_DEPTH  = axil_pkg::IMEM_DEPTH_DEF,
  parameter logic [ADDR_WIDTH-1:0] IMEM_BASE = axil_pkg::IMEM_BASE_DEF
) (
  input logic   i_aclk,
  input logic   i_arst_n,
  axil_if.slave s_axil
);
  import axil_pkg::*;

  localparam int STRB_W  = DATA_WIDTH / 8;
  localparam int OFF_LSB = $clog2(STRB_W);
  localparam int IDX_W   = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
  // Size of the window in bytes
  localparam logic [ADDR_WIDTH-1:0] MEM_BYTES = ADDR_WIDTH'(MEM_DEPTH * STRB_W);

  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

  // Handshake and response registers
  logic                   awready_r;
  logic                   wready_r;
  logic                   bvalid_r;
  logic [AXIL_RESP_W-1:0] bresp_r;
  logic                   arready_r;
  logic                   rvalid_r;
  logic [DATA_WIDTH-1:0]  rdata_r;
  logic [AXIL_RESP_W-1:0] rresp_r;

  // Address decode
  logic [ADDR_WIDTH-1:0] aw_off;
  logic [ADDR_WIDTH-1:0] ar_off;
  logic [IDX_W-1:0]      aw_idx;
  logic [IDX_W-1:0]      ar_idx;
  logic                  aw_hit;
  logic                  ar_hit;

  logic wr_go;
  logic rd_go;

  assign aw_off = s_axil.awaddr - IMEM_BASE;
  assign ar_off = s_axil.araddr - IMEM_BASE;
  assign aw_idx = aw_off[OFF_LSB +: IDX_W];
  assign ar_idx = ar_off[OFF_LSB +: IDX_W];
  // Below the base the offset wraps, so both bounds are checked
  assign aw_hit = (s_axil.awaddr >= IMEM_BASE) && (aw_off < MEM_BYTES);
  assign ar_hit = (s_axil.araddr >= IMEM_BASE) && (ar_off < MEM_BYTES);

  // Accept a write once address and data are both present and the response slot is free
  assign wr_go = s_axil.awvalid && s_axil.wvalid && (!bvalid_r || s_axil.bready) &&
                 !awready_r && !wready_r;
  assign rd_go = s_axil.arvalid && (!rvalid_r || s_axil.rready) && !arready_r;

  assign s_axil.awready = awready_r;
  assign s_axil.wready  = wready_r;
  assign s_axil.bvalid  = bvalid_r;
  assign s_axil.bresp   = bresp_r;
  assign s_axil.arready = arready_r;
  assign s_axil.rvalid  = rvalid_r;
  assign s_axil.rdata   = rdata_r;
  assign s_axil.rresp   = rresp_r;

  // Write side control
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      awready_r <= 1'b0;
      wready_r  <= 1'b0;
      bvalid_r  <= 1'b0;
    end else begin
      // Readies pulse for a single cycle
      awready_r <= wr_go;
      wready_r  <= wr_go;
      if (wr_go) begin
        bvalid_r <= 1'b1;
      end else if (s_axil.bready) begin
        bvalid_r <= 1'b0;
      end
    end
  end

  // Memory update, only strobed bytes of an in-range word
  always_ff @(posedge i_aclk) begin
    if (wr_go) begin
      bresp_r <= aw_hit ? RESP_OKAY : RESP_SLVERR;
      if (aw_hit) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (s_axil.wstrb[b]) begin
            mem[aw_idx][8*b +: 8] <= s_axil.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Read side control
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      arready_r <= 1'b0;
      rvalid_r  <= 1'b0;
    end else begin
      arready_r <= rd_go;
      if (rd_go) begin
        rvalid_r <= 1'b1;
      end else if (s_axil.rready) begin
        rvalid_r <= 1'b0;
      end
    end
  end

  // Read data sees the array before a same-edge write lands
  always_ff @(posedge i_aclk) begin
    if (rd_go) begin
      rdata_r <= ar_hit ? mem[ar_idx] : '0;
      rresp_r <= ar_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

/* hdl/ifu_fetch.sv */
// AXI-lite read master for instruction fetch, one read per strobe and a 32-bit instruction back
module ifu_fetch #(
  parameter int DATA_WIDTH = axil_pkg::AXIL_DATA_W,
  parameter int ADDR_WIDTH = axil_pkg::AXIL_ADDR_W
) (
  input  logic                        i_aclk,
  input  logic                        i_arst_n,
  input  logic                        i_fetch_valid,
  input  logic [ADDR_WIDTH-1:0]       i_pc,
  output logic                        o_fetch_busy,
  output logic                        o_inst_valid,
  output logic [axil_pkg::INST_W-1:0] o_inst,
  output logic                        o_inst_err,
  axil_if.master                      m_axil
);
  import axil_pkg::*;

  localparam int OFF_LSB = $clog2(DATA_WIDTH / 8);

  logic                  busy;
  logic                  arvalid_r;
  logic                  rready_r;
  logic [ADDR_WIDTH-1:0] araddr_r;
  // Upper half of the word holds the instruction when pc bit 2 is set
  logic                  sel_hi;
  logic [INST_W-1:0]     inst_word;
  logic                  start;
  logic                  r_beat;

  assign start  = i_fetch_valid && !busy;
  assign r_beat = busy && m_axil.rvalid && rready_r;

  assign inst_word = sel_hi ? m_axil.rdata[INST_W +: INST_W] : m_axil.rdata[INST_W-1:0];

  assign m_axil.arvalid = arvalid_r;
  assign m_axil.araddr  = araddr_r;
  assign m_axil.arprot  = PROT_INST;
  assign m_axil.rready  = rready_r;

  assign o_fetch_busy = busy;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy         <= 1'b0;
      arvalid_r    <= 1'b0;
      rready_r     <= 1'b0;
      o_inst_valid <= 1'b0;
      o_inst_err   <= 1'b0;
    end else begin
      // Read data is always taken once out of reset
      rready_r     <= 1'b1;
      o_inst_valid <= 1'b0;
      if (start) begin
        busy      <= 1'b1;
        arvalid_r <= 1'b1;
      end else begin
        if (arvalid_r && m_axil.arready) begin
          arvalid_r <= 1'b0;
        end
        if (r_beat) begin
          busy         <= 1'b0;
          o_inst_valid <= 1'b1;
          o_inst_err   <= (m_axil.rresp != RESP_OKAY);
        end
      end
    end
  end

  // Request and instruction payload
  always_ff @(posedge i_aclk) begin
    if (start) begin
      araddr_r <= {i_pc[ADDR_WIDTH-1:OFF_LSB], {OFF_LSB{1'b0}}};
      sel_hi   <= i_pc[2];
    end
    if (r_beat) begin
      o_inst <= (m_axil.rresp == RESP_OKAY) ? inst_word : '0;
    end
  end

endmodule

/* hdl/imem_loader.sv */
// AXI-lite write master that preloads instruction memory, one strobed word per load strobe
module imem_loader #(
  parameter int DATA_WIDTH = axil_pkg::AXIL_DATA_W,
  parameter int ADDR_WIDTH = axil_pkg::AXIL_ADDR_W
) (
  input  logic                    i_aclk,
  input  logic                    i_arst_n,
  input  logic                    i_ld_valid,
  input  logic [ADDR_WIDTH-1:0]   i_ld_addr,
  input  logic [DATA_WIDTH-1:0]   i_ld_data,
  input  logic [DATA_WIDTH/8-1:0] i_ld_strb,
  output logic                    o_ld_busy,
  output logic                    o_ld_done,
  output logic                    o_ld_err,
  axil_if.master                  m_axil
);
  import axil_pkg::*;

  localparam int STRB_W = DATA_WIDTH / 8;

  logic                  busy;
  logic                  awvalid_r;
  logic                  wvalid_r;
  logic                  bready_r;
  logic [ADDR_WIDTH-1:0] awaddr_r;
  logic [DATA_WIDTH-1:0] wdata_r;
  logic [STRB_W-1:0]     wstrb_r;
  logic                  start;
  logic                  b_beat;

  assign start  = i_ld_valid && !busy;
  assign b_beat = busy && m_axil.bvalid && bready_r;

  assign m_axil.awvalid = awvalid_r;
  assign m_axil.awaddr  = awaddr_r;
  assign m_axil.awprot  = PROT_DATA;
  assign m_axil.wvalid  = wvalid_r;
  assign m_axil.wdata   = wdata_r;
  assign m_axil.wstrb   = wstrb_r;
  assign m_axil.bready  = bready_r;

  assign o_ld_busy = busy;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy      <= 1'b0;
      awvalid_r <= 1'b0;
      wvalid_r  <= 1'b0;
      bready_r  <= 1'b0;
      o_ld_done <= 1'b0;
      o_ld_err  <= 1'b0;
    end else begin
      bready_r  <= 1'b1;
      o_ld_done <= 1'b0;
      if (start) begin
        busy      <= 1'b1;
        awvalid_r <= 1'b1;
        wvalid_r  <= 1'b1;
      end else begin
        // Address and data may be accepted in different cycles
        if (awvalid_r && m_axil.awready) begin
          awvalid_r <= 1'b0;
        end
        if (wvalid_r && m_axil.wready) begin
          wvalid_r <= 1'b0;
        end
        if (b_beat) begin
          busy      <= 1'b0;
          o_ld_done <= 1'b1;
          o_ld_err  <= (m_axil.bresp != RESP_OKAY);
        end
      end
    end
  end

  // Captured request, stable until each channel is accepted
  always_ff @(posedge i_aclk) begin
    if (start) begin
      awaddr_r <= i_ld_addr;
      wdata_r  <= i_ld_data;
      wstrb_r  <= i_ld_strb;
    end
  end

endmodule

/* hdl/ifu_mem_top.sv */
// Instruction memory subsystem top, fetch and load requests on plain ports over one AXI-lite bus
module ifu_mem_top #(
  parameter int                    DATA_WIDTH = axil_pkg::AXIL_DATA_W,
  parameter int                    ADDR_WIDTH = axil_pkg::AXIL_ADDR_W,
  parameter int                    MEM_DEPTH  = axil_pkg::IMEM_DEPTH_DEF,
  parameter logic [ADDR_WIDTH-1:0] IMEM_BASE  = axil_pkg::IMEM_BASE_DEF
) (
  input  logic                        i_aclk,
  input  logic                        i_arst_n,
  // Fetch side
  input  logic                        i_fetch_valid,
  input  logic [ADDR_WIDTH-1:0]       i_pc,
  output logic                        o_fetch_busy,
  output logic                        o_inst_valid,
  output logic [axil_pkg::INST_W-1:0] o_inst,
  output logic                        o_inst_err,
  // Loader side
  input  logic                        i_ld_valid,
  input  logic [ADDR_WIDTH-1:0]       i_ld_addr,
  input  logic [DATA_WIDTH-1:0]       i_ld_data,
  input  logic [DATA_WIDTH/8-1:0]     i_ld_strb,
  output logic                        o_ld_busy,
  output logic                        o_ld_done,
  output logic                        o_ld_err
);

  // Loader owns the write channels, fetch owns the read channels
  axil_if #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_axil ();

  axil_inst_sram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH),
    .IMEM_BASE  (IMEM_BASE)
  ) u_sram (
    .i_aclk   (i_aclk),
    .i_arst_n (i_arst_n),
    .s_axil   (u_axil.slave)
  );

  ifu_fetch #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_fetch (
    .i_aclk        (i_aclk),
    .i_arst_n      (i_arst_n),
    .i_fetch_valid (i_fetch_valid),
    .i_pc          (i_pc),
    .o_fetch_busy  (o_fetch_busy),
    .o_inst_valid  (o_inst_valid),
    .o_inst        (o_inst),
    .o_inst_err    (o_inst_err),
    .m_axil        (u_axil.master)
  );

  imem_loader #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_loader (
    .i_aclk     (i_aclk),
    .i_arst_n   (i_arst_n),
    .i_ld_valid (i_ld_valid),
    .i_ld_addr  (i_ld_addr),
    .i_ld_data  (i_ld_data),
    .i_ld_strb  (i_ld_strb),
    .o_ld_busy  (o_ld_busy),
    .o_ld_done  (o_ld_done),
    .o_ld_err   (o_ld_err),
    .m_axil     (u_axil.master)
  );

endmodule

/* verif/tb_ifu_mem_top.sv */
// Testbench for ifu_mem_top, replays the cases file against a byte-strobe memory model
module tb_ifu_mem_top;

  localparam logic [31:0] MEM_BASE  = 32'h8000_0000;
  localparam int          MEM_WORDS = 256;
  localparam logic [31:0] WIN_BYTES = 32'(MEM_WORDS * 8);
  localparam int          TIMEOUT   = 50;

  logic        aclk;
  logic        arst_n;
  logic        fetch_valid;
  logic [31:0] pc;
  logic        fetch_busy;
  logic        inst_valid;
  logic [31:0] inst;
  logic        inst_err;
  logic        ld_valid;
  logic [31:0] ld_addr;
  logic [63:0] ld_data;
  logic [7:0]  ld_strb;
  logic        ld_busy;
  logic        ld_done;
  logic        ld_err;

  // Reference copy of every word written so far keyed by word index
  logic [63:0] model_mem [int];
  int          mism_errs;
  int          other_errs;

  ifu_mem_top #(
    .DATA_WIDTH (64),
    .ADDR_WIDTH (32),
    .MEM_DEPTH  (MEM_WORDS),
    .IMEM_BASE  (MEM_BASE)
  ) i_ifu_mem_top (
    .i_aclk        (aclk),
    .i_arst_n      (arst_n),
    .i_fetch_valid (fetch_valid),
    .i_pc          (pc),
    .o_fetch_busy  (fetch_busy),
    .o_inst_valid  (inst_valid),
    .o_inst        (inst),
    .o_inst_err    (inst_err),
    .i_ld_valid    (ld_valid),
    .i_ld_addr     (ld_addr),
    .i_ld_data     (ld_data),
    .i_ld_strb     (ld_strb),
    .o_ld_busy     (ld_busy),
    .o_ld_done     (ld_done),
    .o_ld_err      (ld_err)
  );

  always #10 aclk = ~aclk;

  function automatic bit in_window(input logic [31:0] addr);
    return (addr >= MEM_BASE) && ((addr - MEM_BASE) < WIN_BYTES);
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_w, input logic [63:0] new_w,
                                              input logic [7:0] strb);
    logic [63:0] res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic model_fetch(input string name, input logic [31:0] addr, output bit err,
                             output logic [31:0] word_out);
    int          idx;
    logic [63:0] w;
    err = !in_window(addr);
    word_out = '0;
    if (!err) begin
      idx = int'((addr - MEM_BASE) >> 3);
      w = '0;
      if (model_mem.exists(idx)) begin
        w = model_mem[idx];
      end else begin
        $display("%s: fetch of a word that no earlier case has loaded", name);
        other_errs++;
      end
      word_out = addr[2] ? w[63:32] : w[31:0];
    end
  endtask

  task automatic model_load(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb, output bit err);
    int          idx;
    logic [63:0] w;
    err = !in_window(addr);
    if (!err) begin
      idx = int'((addr - MEM_BASE) >> 3);
      w = model_mem.exists(idx) ? model_mem[idx] : 64'h0;
      model_mem[idx] = merge_bytes(w, data, strb);
    end
  endtask

  task automatic wait_idle(input string name, input bit do_ld, input bit do_fetch);
    int cnt;
    cnt = 0;
    @(negedge aclk);
    while (((do_ld && ld_busy) || (do_fetch && fetch_busy)) && cnt < TIMEOUT) begin
      @(negedge aclk);
      cnt++;
    end
    if ((do_ld && ld_busy) || (do_fetch && fetch_busy)) begin
      $display("%s: timed out waiting for the busy outputs to drop", name);
      other_errs++;
    end
  endtask

  // One-cycle request strobe driven just after the rising edge
  task automatic issue(input bit do_ld, input bit do_fetch, input logic [31:0] addr,
                       input logic [63:0] data, input logic [7:0] strb, input logic [31:0] fpc);
    @(posedge aclk);
    #2;
    ld_valid    = do_ld;
    ld_addr     = addr;
    ld_data     = data;
    ld_strb     = strb;
    fetch_valid = do_fetch;
    pc          = fpc;
    @(posedge aclk);
    #2;
    ld_valid    = 1'b0;
    fetch_valid = 1'b0;
  endtask

  task automatic wait_done(input string name, input bit do_ld, input bit do_fetch,
                           output bit ld_err_q, output bit inst_err_q,
                           output logic [31:0] inst_q, output bit ok);
    int cnt;
    bit ld_seen;
    bit fe_seen;
    cnt = 0;
    ld_seen = !do_ld;
    fe_seen = !do_fetch;
    ld_err_q = 1'b0;
    inst_err_q = 1'b0;
    inst_q = '0;
    while (!(ld_seen && fe_seen) && cnt < TIMEOUT) begin
      @(negedge aclk);
      cnt++;
      // Busy is up in the first cycle after the strobe is taken
      if (cnt == 1) begin
        if (do_ld && ld_busy !== 1'b1) begin
          $display("mismatch %s o_ld_busy expected 1 actual %b", name, ld_busy);
          mism_errs++;
        end
        if (do_fetch && fetch_busy !== 1'b1) begin
          $display("mismatch %s o_fetch_busy expected 1 actual %b", name, fetch_busy);
          mism_errs++;
        end
      end
      if (do_ld && ld_done) begin
        ld_seen = 1'b1;
        ld_err_q = ld_err;
      end
      if (do_fetch && inst_valid) begin
        fe_seen = 1'b1;
        inst_err_q = inst_err;
        inst_q = inst;
      end
    end
    ok = ld_seen && fe_seen;
    if (!ok) begin
      $display("%s: timed out waiting for the request to complete", name);
      other_errs++;
    end
  endtask

  initial begin
    int          fd;
    int          code;
    int          gap;
    int unsigned seed_ret;
    string       line;
    string       name;
    string       op;
    logic [31:0] c_addr;
    logic [63:0] c_data;
    logic [7:0]  c_strb;
    logic [31:0] c_pc;
    int          exp_err;
    logic [31:0] exp_inst;
    bit          do_ld;
    bit          do_fetch;
    bit          m_ld_err;
    bit          m_inst_err;
    logic [31:0] m_inst;
    bit          got_ld_err;
    bit          got_inst_err;
    logic [31:0] got_inst;
    bit          ok;

    mism_errs = 0;
    other_errs = 0;
    seed_ret = $urandom(55191);
    aclk = 1'b0;
    arst_n = 1'b0;
    fetch_valid = 1'b0;
    pc = '0;
    ld_valid = 1'b0;
    ld_addr = '0;
    ld_data = '0;
    ld_strb = '0;
    repeat (5) @(posedge aclk);
    #2;
    arst_n = 1'b1;
    @(negedge aclk);
    // Bit order is o_inst_valid, o_ld_done, o_fetch_busy, o_ld_busy
    if ({inst_valid, ld_done, fetch_busy, ld_busy} !== 4'b0000) begin
      $display("mismatch reset status expected %b actual %b", 4'b0000,
               {inst_valid, ld_done, fetch_busy, ld_busy});
      mism_errs++;
    end

    fd = $fopen("verif/ifu_mem_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the cases file verif/ifu_mem_cases.txt");
      other_errs++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
          continue;
        end
        code = $sscanf(line, "%s %s %h %h %h %h %d %h", name, op, c_addr, c_data, c_strb,
                       c_pc, exp_err, exp_inst);
        if (code != 8) begin
          $display("malformed line in the cases file: %s", line);
          other_errs++;
          continue;
        end
        do_ld = (op == "load") || (op == "both");
        do_fetch = (op == "fetch") || (op == "both");
        // Predict the fetch before the load since a same-cycle load lands after the read
        m_inst_err = 1'b0;
        m_inst = '0;
        m_ld_err = 1'b0;
        if (do_fetch) begin
          model_fetch(name, c_pc, m_inst_err, m_inst);
        end
        if (do_ld) begin
          model_load(c_addr, c_data, c_strb, m_ld_err);
        end
        if ((do_ld && m_ld_err != (exp_err != 0)) ||
            (do_fetch && (m_inst_err != (exp_err != 0) || m_inst != exp_inst))) begin
          $display("%s: cases file expectation disagrees with the reference model", name);
          other_errs++;
        end
        wait_idle(name, do_ld, do_fetch);
        issue(do_ld, do_fetch, c_addr, c_data, c_strb, c_pc);
        wait_done(name, do_ld, do_fetch, got_ld_err, got_inst_err, got_inst, ok);
        if (ok && do_ld && got_ld_err != m_ld_err) begin
          $display("mismatch %s o_ld_err expected %0d actual %0d", name, m_ld_err, got_ld_err);
          mism_errs++;
        end
        if (ok && do_fetch && got_inst_err != m_inst_err) begin
          $display("mismatch %s o_inst_err expected %0d actual %0d", name, m_inst_err,
                   got_inst_err);
          mism_errs++;
        end
        if (ok && do_fetch && got_inst !== m_inst) begin
          $display("mismatch %s o_inst expected %h actual %h", name, m_inst, got_inst);
          mism_errs++;
        end
        gap = $urandom_range(3);
        repeat (gap) @(posedge aclk);
      end
      $fclose(fd);
    end

    $display("errors: %0d mismatches, %0d other failures", mism_errs, other_errs);
    if (mism_errs + other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verif/ifu_mem_cases.txt */
# Columns: name op ld_addr ld_data ld_strb pc exp_err exp_inst (all hex except name, op, exp_err)
# op load uses ld_*, fetch uses pc, both issues a load and a fetch in the same cycle
# exp_err is the error expected from each issued request, exp_inst the fetched instruction
ld_w0        load  80000000 1122334455667788 ff 00000000 0 00000000
fe_w0_lo     fetch 00000000 0000000000000000 00 80000000 0 55667788
fe_w0_hi     fetch 00000000 0000000000000000 00 80000004 0 11223344
ld_w1        load  80000008 0000006f00000013 ff 00000000 0 00000000
fe_w1_lo     fetch 00000000 0000000000000000 00 80000008 0 00000013
fe_w1_hi     fetch 00000000 0000000000000000 00 8000000c 0 0000006f
ld_w0_part   load  80000000 aaaaaaaabbbbbbbb 3c 00000000 0 00000000
fe_part_lo   fetch 00000000 0000000000000000 00 80000000 0 bbbb7788
fe_part_hi   fetch 00000000 0000000000000000 00 80000004 0 1122aaaa
ld_w1_byte   load  80000008 00000000000000ff 01 00000000 0 00000000
fe_byte_lo   fetch 00000000 0000000000000000 00 80000008 0 000000ff
ld_oob_hi    load  80000800 deadbeefdeadbeef ff 00000000 1 00000000
ld_oob_lo    load  7ffffff8 deadbeefdeadbeef ff 00000000 1 00000000
fe_oob_hi    fetch 00000000 0000000000000000 00 80000800 1 00000000
fe_oob_lo    fetch 00000000 0000000000000000 00 7ffffffc 1 00000000
fe_keep_lo   fetch 00000000 0000000000000000 00 80000000 0 bbbb7788
fe_keep_hi   fetch 00000000 0000000000000000 00 80000004 0 1122aaaa
ld_last      load  800007f8 0123456789abcdef ff 00000000 0 00000000
fe_last_hi   fetch 00000000 0000000000000000 00 800007fc 0 01234567
both_w2_w0   both  80000010 cafef00d12345678 ff 80000004 0 1122aaaa
fe_w2_lo     fetch 00000000 0000000000000000 00 80000010 0 12345678
both_w0_w1   both  80000000 ffffffff00000000 f0 8000000c 0 0000006f
fe_w0_new_hi fetch 00000000 0000000000000000 00 80000004 0 ffffffff
fe_w0_new_lo fetch 00000000 0000000000000000 00 80000000 0 bbbb7788
ld_w3        load  80000018 00c5851300a00593 ff 00000000 0 00000000
ld_w3_mid    load  80000018 0000000000110000 04 00000000 0 00000000
fe_w3_lo     fetch 00000000 0000000000000000 00 80000018 0 00110593
fe_w3_hi     fetch 00000000 0000000000000000 00 8000001c 0 00c58513
fe_w2_hi     fetch 00000000 0000000000000000 00 80000014 0 cafef00d

/* src.f */
hdl/axil_pkg.sv
hdl/axil_if.sv
hdl/axil_inst_sram.sv
hdl/ifu_fetch.sv
hdl/imem_loader.sv
hdl/ifu_mem_top.sv
verif/tb_ifu_mem_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module tb_ifu_mem_top -f src.f -Mdir obj_dir -o sim_tb &&
  ./obj_dir/sim_tb > "$LOG" 2>&1 ||
  { cat "$LOG" 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat "$LOG"
grep -q "TEST RESULT: FAIL" "$LOG" && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" "$LOG" || { echo "No result line found in $LOG"; exit 1; }
exit 0
